// File: dram_geom_pkg.sv
//**********************************************************
// widths and depths of the processor side, the command
// queue and the memory controller application side
//**********************************************************
`default_nettype none

package dram_geom_pkg;

    // processor side
    localparam int USER_ADDR_W = 32;
    localparam int USER_DATA_W = 32;
    localparam int USER_MASK_W = 4;

    // application side of the memory controller
    localparam int APP_ADDR_W = 27;
    localparam int APP_DATA_W = 128;
    localparam int APP_MASK_W = 16;

    // command queue
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = 2;

endpackage

`default_nettype wire

// File: dram_app_pkg.sv
//**********************************************************
// command codes and mask constants of the application port
//**********************************************************
`default_nettype none

package dram_app_pkg;

    localparam int APP_CMD_W = 3;

    localparam logic [APP_CMD_W-1:0] CMD_WRITE = 3'b000;
    localparam logic [APP_CMD_W-1:0] CMD_READ  = 3'b001;

    // upper byte lanes above the 32-bit word, always masked
    localparam int APP_MASK_FILL_W = 12;

endpackage

`default_nettype wire

// File: dram_req_if.sv
//**********************************************************
// one processor request moving between pipeline stages,
// valid/ready handshake, payload held until the transfer
//**********************************************************
`default_nettype none

interface dram_req_if;

    logic                                   valid;
    logic                                   wr;
    logic [dram_geom_pkg::USER_ADDR_W-1:0]  addr;
    logic [dram_geom_pkg::USER_DATA_W-1:0]  data;
    logic [dram_geom_pkg::USER_MASK_W-1:0]  mask;
    logic                                   ready;

    modport src (
        output valid, wr, addr, data, mask,
        input  ready
    );

    modport dst (
        input  valid, wr, addr, data, mask,
        output ready
    );

endinterface

`default_nettype wire

// File: user_req_stage.sv
//**********************************************************
// processor-side request FSM, waits for calibration, pushes
// one request at a time and returns the read word
//**********************************************************
`default_nettype none

module user_req_stage (
    input  logic                                  clk,
    input  logic                                  rst_x_async,
    input  logic                                  i_init_calib_complete,
    input  logic                                  i_wr_en,
    input  logic                                  i_rd_en,
    input  logic [dram_geom_pkg::USER_ADDR_W-1:0] i_addr,
    input  logic [dram_geom_pkg::USER_DATA_W-1:0] i_data,
    input  logic [dram_geom_pkg::USER_MASK_W-1:0] i_mask,
    input  logic [dram_geom_pkg::APP_DATA_W-1:0]  i_app_rd_data,
    input  logic                                  i_app_rd_data_valid,
    output logic                                  o_busy,
    output logic [dram_geom_pkg::APP_DATA_W-1:0]  o_data,
    dram_req_if.src                               req_q_if
);

    localparam logic [1:0] ST_CALIB = 2'd0;
    localparam logic [1:0] ST_IDLE  = 2'd1;
    localparam logic [1:0] ST_WRITE = 2'd2;
    localparam logic [1:0] ST_READ  = 2'd3;

    logic [1:0] state;
    logic       req_sampled;
    logic       push_done;
    logic       rd_return;

    assign req_sampled = (state == ST_IDLE) && (i_wr_en || i_rd_en);
    assign push_done   = req_q_if.valid && req_q_if.ready;
    // read pushed already, data comes back
    assign rd_return   = (state == ST_READ) && !req_q_if.valid && i_app_rd_data_valid;

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state          <= ST_CALIB;
            req_q_if.valid <= 1'b0;
        end else begin
            case (state)
                ST_CALIB: begin
                    if (i_init_calib_complete) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    // write wins over read
                    if (i_wr_en) begin
                        state          <= ST_WRITE;
                        req_q_if.valid <= 1'b1;
                    end else if (i_rd_en) begin
                        state          <= ST_READ;
                        req_q_if.valid <= 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (push_done) begin
                        state          <= ST_IDLE;
                        req_q_if.valid <= 1'b0;
                    end
                end
                default: begin
                    if (push_done) begin
                        req_q_if.valid <= 1'b0;
                    end
                    if (rd_return) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_sampled) begin
            req_q_if.wr   <= i_wr_en;
            req_q_if.addr <= i_addr;
            req_q_if.data <= i_data;
            // reads carry no byte enables
            req_q_if.mask <= i_wr_en ? i_mask : '0;
        end
        if (rd_return) begin
            o_data <= i_app_rd_data;
        end
    end

    assign o_busy = (state != ST_IDLE);

endmodule

`default_nettype wire

// File: req_queue.sv
//**********************************************************
// synchronous circular command queue, ready is not-full on
// the input side and valid is not-empty on the output side
//**********************************************************
`default_nettype none

module req_queue (
    input  logic    clk,
    input  logic    rst_x_async,
    dram_req_if.dst q_in,
    dram_req_if.src q_out
);

    logic                                   mem_wr   [0:dram_geom_pkg::QUEUE_DEPTH-1];
    logic [dram_geom_pkg::USER_ADDR_W-1:0]  mem_addr [0:dram_geom_pkg::QUEUE_DEPTH-1];
    logic [dram_geom_pkg::USER_DATA_W-1:0]  mem_data [0:dram_geom_pkg::QUEUE_DEPTH-1];
    logic [dram_geom_pkg::USER_MASK_W-1:0]  mem_mask [0:dram_geom_pkg::QUEUE_DEPTH-1];

    logic [dram_geom_pkg::QUEUE_PTR_W-1:0]  wr_ptr;
    logic [dram_geom_pkg::QUEUE_PTR_W-1:0]  rd_ptr;
    logic [dram_geom_pkg::QUEUE_PTR_W:0]    count;
    logic                                   push;
    logic                                   pop;

    assign push = q_in.valid && q_in.ready;
    assign pop  = q_out.valid && q_out.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_wr[wr_ptr]   <= q_in.wr;
            mem_addr[wr_ptr] <= q_in.addr;
            mem_data[wr_ptr] <= q_in.data;
            mem_mask[wr_ptr] <= q_in.mask;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign q_in.ready  = (count != dram_geom_pkg::QUEUE_DEPTH);
    assign q_out.valid = (count != '0);
    assign q_out.wr    = mem_wr[rd_ptr];
    assign q_out.addr  = mem_addr[rd_ptr];
    assign q_out.data  = mem_data[rd_ptr];
    assign q_out.mask  = mem_mask[rd_ptr];

endmodule

`default_nettype wire

// File: app_cmd_issuer.sv
//**********************************************************
// takes queued requests and drives the application command
// and write-data handshakes, each held until its own ready
//**********************************************************
`default_nettype none

module app_cmd_issuer (
    input  logic                                   clk,
    input  logic                                   rst_x_async,
    input  logic                                   i_app_rdy,
    input  logic                                   i_app_wdf_rdy,
    dram_req_if.dst                                issue_if,
    output logic                                   o_app_en,
    output logic [dram_app_pkg::APP_CMD_W-1:0]     o_app_cmd,
    output logic [dram_geom_pkg::APP_ADDR_W-1:0]   o_app_addr,
    output logic                                   o_app_wdf_wren,
    output logic [dram_geom_pkg::APP_DATA_W-1:0]   o_app_wdf_data,
    output logic [dram_geom_pkg::APP_MASK_W-1:0]   o_app_wdf_mask
);

    localparam logic [1:0] ST_IDLE       = 2'd0;
    localparam logic [1:0] ST_CMD_WDATA  = 2'd1;
    localparam logic [1:0] ST_CMD_ONLY   = 2'd2;
    localparam logic [1:0] ST_WDATA_ONLY = 2'd3;

    localparam int DATA_PAD_W = dram_geom_pkg::APP_DATA_W - dram_geom_pkg::USER_DATA_W;

    logic [1:0] state;
    logic       take;

    // a new entry only once both handshakes are done
    assign issue_if.ready = (state == ST_IDLE);
    assign take           = issue_if.valid && issue_if.ready;

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state          <= ST_IDLE;
            o_app_en       <= 1'b0;
            o_app_wdf_wren <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        o_app_en       <= 1'b1;
                        o_app_wdf_wren <= issue_if.wr;
                        state          <= issue_if.wr ? ST_CMD_WDATA : ST_CMD_ONLY;
                    end
                end
                ST_CMD_WDATA: begin
                    if (i_app_rdy && i_app_wdf_rdy) begin
                        o_app_en       <= 1'b0;
                        o_app_wdf_wren <= 1'b0;
                        state          <= ST_IDLE;
                    end else if (i_app_rdy) begin
                        o_app_en <= 1'b0;
                        state    <= ST_WDATA_ONLY;
                    end else if (i_app_wdf_rdy) begin
                        o_app_wdf_wren <= 1'b0;
                        state          <= ST_CMD_ONLY;
                    end
                end
                ST_CMD_ONLY: begin
                    if (i_app_rdy) begin
                        o_app_en <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: begin
                    if (i_app_wdf_rdy) begin
                        o_app_wdf_wren <= 1'b0;
                        state          <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            o_app_cmd  <= issue_if.wr ? dram_app_pkg::CMD_WRITE : dram_app_pkg::CMD_READ;
            // byte address halved onto the application address
            o_app_addr <= {1'b0, issue_if.addr[dram_geom_pkg::APP_ADDR_W-1:1]};
            o_app_wdf_data <= {{DATA_PAD_W{1'b0}}, issue_if.data};
            o_app_wdf_mask <= {{dram_app_pkg::APP_MASK_FILL_W{1'b1}}, issue_if.mask};
        end
    end

endmodule

`default_nettype wire

// File: dram_ctrl_top.sv
//**********************************************************
// DRAM request front end, processor port in, memory
// controller application port out, single clock
//**********************************************************
`default_nettype none

module dram_ctrl_top (
    input  logic                                  clk,
    input  logic                                  rst_x_async,
    input  logic                                  i_init_calib_complete,
    input  logic                                  i_wr_en,
    input  logic                                  i_rd_en,
    input  logic [dram_geom_pkg::USER_ADDR_W-1:0] i_addr,
    input  logic [dram_geom_pkg::USER_DATA_W-1:0] i_data,
    input  logic [dram_geom_pkg::USER_MASK_W-1:0] i_mask,
    output logic                                  o_busy,
    output logic [dram_geom_pkg::APP_DATA_W-1:0]  o_data,
    input  logic                                  i_app_rdy,
    input  logic                                  i_app_wdf_rdy,
    input  logic [dram_geom_pkg::APP_DATA_W-1:0]  i_app_rd_data,
    input  logic                                  i_app_rd_data_valid,
    output logic                                  o_app_en,
    output logic [2:0]                            o_app_cmd,
    output logic [dram_geom_pkg::APP_ADDR_W-1:0]  o_app_addr,
    output logic                                  o_app_wdf_wren,
    output logic [dram_geom_pkg::APP_DATA_W-1:0]  o_app_wdf_data,
    output logic [dram_geom_pkg::APP_MASK_W-1:0]  o_app_wdf_mask
);

    dram_req_if req_q_if ();
    dram_req_if issue_if ();

    user_req_stage u_user_req_stage (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        .i_init_calib_complete (i_init_calib_complete),
        .i_wr_en               (i_wr_en),
        .i_rd_en               (i_rd_en),
        .i_addr                (i_addr),
        .i_data                (i_data),
        .i_mask                (i_mask),
        .i_app_rd_data         (i_app_rd_data),
        .i_app_rd_data_valid   (i_app_rd_data_valid),
        .o_busy                (o_busy),
        .o_data                (o_data),
        .req_q_if              (req_q_if.src)
    );

    req_queue u_req_queue (
        .clk         (clk),
        .rst_x_async (rst_x_async),
        .q_in        (req_q_if.dst),
        .q_out       (issue_if.src)
    );

    app_cmd_issuer u_app_cmd_issuer (
        .clk            (clk),
        .rst_x_async    (rst_x_async),
        .i_app_rdy      (i_app_rdy),
        .i_app_wdf_rdy  (i_app_wdf_rdy),
        .issue_if       (issue_if.dst),
        .o_app_en       (o_app_en),
        .o_app_cmd      (o_app_cmd),
        .o_app_addr     (o_app_addr),
        .o_app_wdf_wren (o_app_wdf_wren),
        .o_app_wdf_data (o_app_wdf_data),
        .o_app_wdf_mask (o_app_wdf_mask)
    );

endmodule

`default_nettype wire

// File: dram_app_model.sv
//**********************************************************
// memory controller application side for the testbench,
// random ready, byte-masked memory, delayed read return
//**********************************************************
`default_nettype none

module dram_app_model (
    input  logic                                  clk,
    input  logic                                  rst_x_async,
    input  logic                                  i_app_en,
    input  logic [dram_app_pkg::APP_CMD_W-1:0]    i_app_cmd,
    input  logic [dram_geom_pkg::APP_ADDR_W-1:0]  i_app_addr,
    input  logic                                  i_app_wdf_wren,
    input  logic [dram_geom_pkg::APP_DATA_W-1:0]  i_app_wdf_data,
    input  logic [dram_geom_pkg::APP_MASK_W-1:0]  i_app_wdf_mask,
    output logic                                  o_app_rdy,
    output logic                                  o_app_wdf_rdy,
    output logic [dram_geom_pkg::APP_DATA_W-1:0]  o_app_rd_data,
    output logic                                  o_app_rd_data_valid,
    output logic                                  o_init_calib_complete,
    output logic                                  o_seen_stb,
    output logic [dram_app_pkg::APP_CMD_W-1:0]    o_seen_cmd,
    output logic [dram_geom_pkg::APP_ADDR_W-1:0]  o_seen_addr,
    output logic [dram_geom_pkg::APP_DATA_W-1:0]  o_seen_data,
    output logic [dram_geom_pkg::APP_MASK_W-1:0]  o_seen_mask
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [dram_geom_pkg::APP_DATA_W-1:0]  mem [logic [dram_geom_pkg::APP_ADDR_W-1:0]];
    logic [dram_geom_pkg::APP_DATA_W-1:0]  rd_q [$];
    int                                    due_q [$];
    int                                    cyc;
    logic                                  cmd_got;
    logic                                  dat_got;
    logic [dram_app_pkg::APP_CMD_W-1:0]    cmd_hold;
    logic [dram_geom_pkg::APP_ADDR_W-1:0]  addr_hold;
    logic [dram_geom_pkg::APP_DATA_W-1:0]  dat_hold;
    logic [dram_geom_pkg::APP_MASK_W-1:0]  mask_hold;
    logic [dram_geom_pkg::APP_DATA_W-1:0]  word;

    // unwritten words read back as a pattern of their own address
    function automatic logic [dram_geom_pkg::APP_DATA_W-1:0] word_at(
        input logic [dram_geom_pkg::APP_ADDR_W-1:0] a
    );
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {4{5'b01101, a}};
    endfunction

    initial begin
        cyc                   = 0;
        cmd_got               = 1'b0;
        dat_got               = 1'b0;
        o_app_rdy             = 1'b0;
        o_app_wdf_rdy         = 1'b0;
        o_app_rd_data         = '0;
        o_app_rd_data_valid   = 1'b0;
        o_init_calib_complete = 1'b0;
        o_seen_stb            = 1'b0;
    end

    // ready, calibration and read return change on the falling edge
    always @(negedge clk) begin
        if (!rst_x_async) begin
            cyc                   <= 0;
            o_app_rdy             <= 1'b0;
            o_app_wdf_rdy         <= 1'b0;
            o_app_rd_data_valid   <= 1'b0;
            o_init_calib_complete <= 1'b0;
        end else begin
            cyc                   <= cyc + 1;
            o_init_calib_complete <= (cyc >= 20);
            o_app_rdy             <= ($urandom % 2) == 0;
            o_app_wdf_rdy         <= ($urandom % 2) == 0;
            o_app_rd_data_valid   <= 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cyc) begin
                o_app_rd_data_valid <= 1'b1;
                o_app_rd_data       <= rd_q.pop_front();
                void'(due_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        o_seen_stb <= 1'b0;
        if (!rst_x_async) begin
            cmd_got = 1'b0;
            dat_got = 1'b0;
        end else begin
            if (i_app_en && o_app_rdy) begin
                cmd_got   = 1'b1;
                cmd_hold  = i_app_cmd;
                addr_hold = i_app_addr;
            end
            if (i_app_wdf_wren && o_app_wdf_rdy) begin
                dat_got   = 1'b1;
                dat_hold  = i_app_wdf_data;
                mask_hold = i_app_wdf_mask;
            end
            if (cmd_got && cmd_hold == dram_app_pkg::CMD_READ) begin
                rd_q.push_back(word_at(addr_hold));
                due_q.push_back(cyc + 2 + int'($urandom % 5));
                o_seen_stb  <= 1'b1;
                o_seen_cmd  <= cmd_hold;
                o_seen_addr <= addr_hold;
                o_seen_data <= '0;
                o_seen_mask <= '0;
                cmd_got = 1'b0;
            end else if (cmd_got && dat_got) begin
                word = word_at(addr_hold);
                // a set mask bit keeps the stored byte
                for (int lane = 0; lane < dram_geom_pkg::APP_MASK_W; lane++) begin
                    if (!mask_hold[lane]) begin
                        word[8*lane +: 8] = dat_hold[8*lane +: 8];
                    end
                end
                mem[addr_hold] = word;
                o_seen_stb  <= 1'b1;
                o_seen_cmd  <= cmd_hold;
                o_seen_addr <= addr_hold;
                o_seen_data <= dat_hold;
                o_seen_mask <= mask_hold;
                cmd_got = 1'b0;
                dat_got = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: dram_ctrl_properties.sv
//**********************************************************
// handshake assertions on the application port, bound
// into app_cmd_issuer
//**********************************************************
`default_nettype none

module dram_ctrl_properties (
    input logic                                  clk,
    input logic                                  rst_x_async,
    input logic                                  i_app_rdy,
    input logic                                  i_app_wdf_rdy,
    input logic                                  i_app_en,
    input logic [dram_app_pkg::APP_CMD_W-1:0]    i_app_cmd,
    input logic [dram_geom_pkg::APP_ADDR_W-1:0]  i_app_addr,
    input logic                                  i_app_wdf_wren,
    input logic [dram_geom_pkg::APP_DATA_W-1:0]  i_app_wdf_data,
    input logic [dram_geom_pkg::APP_MASK_W-1:0]  i_app_wdf_mask
);
    timeunit 1ns;
    timeprecision 1ps;

    // command held with its payload until app_rdy
    cmd_hold_a : assert property (@(posedge clk) disable iff (!rst_x_async)
        (i_app_en && !i_app_rdy) |=> (i_app_en && $stable(i_app_cmd) && $stable(i_app_addr)))
        else $error("app command dropped or changed before app_rdy");

    wdf_hold_a : assert property (@(posedge clk) disable iff (!rst_x_async)
        (i_app_wdf_wren && !i_app_wdf_rdy)
            |=> (i_app_wdf_wren && $stable(i_app_wdf_data) && $stable(i_app_wdf_mask)))
        else $error("write data dropped or changed before app_wdf_rdy");

    reset_idle_a : assert property (@(posedge clk)
        !rst_x_async |-> (!i_app_en && !i_app_wdf_wren))
        else $error("application enables high during reset");

endmodule

bind app_cmd_issuer dram_ctrl_properties u_issuer_props (
    .clk            (clk),
    .rst_x_async    (rst_x_async),
    .i_app_rdy      (i_app_rdy),
    .i_app_wdf_rdy  (i_app_wdf_rdy),
    .i_app_en       (o_app_en),
    .i_app_cmd      (o_app_cmd),
    .i_app_addr     (o_app_addr),
    .i_app_wdf_wren (o_app_wdf_wren),
    .i_app_wdf_data (o_app_wdf_data),
    .i_app_wdf_mask (o_app_wdf_mask)
);

`default_nettype wire

// File: dram_ctrl_tb.sv
//**********************************************************
// random reads and writes over a small address pool drive the
// DRAM request front end and are checked against a model
//**********************************************************
`default_nettype none

module dram_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_REQ    = 300;
    localparam int POOL_SIZE  = 16;
    localparam int MAX_CYCLES = NUM_REQ * 40;

    logic         clk;
    logic         rst_x_async;
    logic         i_wr_en;
    logic         i_rd_en;
    logic [31:0]  i_addr;
    logic [31:0]  i_data;
    logic [3:0]   i_mask;
    logic         o_busy;
    logic [127:0] o_data;
    logic         calib;
    logic         app_rdy;
    logic         app_wdf_rdy;
    logic [127:0] rd_data;
    logic         rd_valid;
    logic         app_en;
    logic [2:0]   app_cmd;
    logic [26:0]  app_addr;
    logic         wdf_wren;
    logic [127:0] wdf_data;
    logic [15:0]  wdf_mask;
    logic         seen_stb;
    logic [2:0]   seen_cmd;
    logic [26:0]  seen_addr;
    logic [127:0] seen_data;
    logic [15:0]  seen_mask;

    logic [31:0]  pool [POOL_SIZE];
    logic [127:0] exp_mem [logic [26:0]];
    logic [2:0]   exp_cmd_q [$];
    logic [26:0]  exp_addr_q [$];
    logic [127:0] exp_data_q [$];
    logic [15:0]  exp_mask_q [$];
    logic [2:0]   exp_cmd;
    int           cycles = 0;

    dram_ctrl_top UUT (
        .clk (clk), .rst_x_async (rst_x_async),
        .i_init_calib_complete (calib),
        .i_wr_en (i_wr_en), .i_rd_en (i_rd_en),
        .i_addr (i_addr), .i_data (i_data), .i_mask (i_mask),
        .o_busy (o_busy), .o_data (o_data),
        .i_app_rdy (app_rdy), .i_app_wdf_rdy (app_wdf_rdy),
        .i_app_rd_data (rd_data), .i_app_rd_data_valid (rd_valid),
        .o_app_en (app_en), .o_app_cmd (app_cmd), .o_app_addr (app_addr),
        .o_app_wdf_wren (wdf_wren), .o_app_wdf_data (wdf_data), .o_app_wdf_mask (wdf_mask)
    );

    dram_app_model u_mem (
        .clk (clk), .rst_x_async (rst_x_async),
        .i_app_en (app_en), .i_app_cmd (app_cmd), .i_app_addr (app_addr),
        .i_app_wdf_wren (wdf_wren), .i_app_wdf_data (wdf_data), .i_app_wdf_mask (wdf_mask),
        .o_app_rdy (app_rdy), .o_app_wdf_rdy (app_wdf_rdy),
        .o_app_rd_data (rd_data), .o_app_rd_data_valid (rd_valid),
        .o_init_calib_complete (calib),
        .o_seen_stb (seen_stb), .o_seen_cmd (seen_cmd), .o_seen_addr (seen_addr),
        .o_seen_data (seen_data), .o_seen_mask (seen_mask)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // same address pattern as the memory model for never-written words
    function automatic logic [127:0] expected_word(input logic [26:0] a);
        if (exp_mem.exists(a)) begin
            return exp_mem[a];
        end
        return {4{5'b01101, a}};
    endfunction

    task automatic send_request(input logic wr, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] mask);
        logic [26:0]  a;
        logic [127:0] full_data;
        logic [15:0]  full_mask;
        logic [127:0] word;
        a         = {1'b0, addr[26:1]};
        full_data = {96'h0, data};
        full_mask = {12'hfff, mask};
        word      = expected_word(a);
        if (wr) begin
            for (int lane = 0; lane < 16; lane++) begin
                if (!full_mask[lane]) begin
                    word[8*lane +: 8] = full_data[8*lane +: 8];
                end
            end
            exp_mem[a] = word;
        end
        exp_cmd_q.push_back(wr ? dram_app_pkg::CMD_WRITE : dram_app_pkg::CMD_READ);
        exp_addr_q.push_back(a);
        exp_data_q.push_back(full_data);
        exp_mask_q.push_back(full_mask);
        i_wr_en = wr;
        i_rd_en = !wr;
        i_addr  = addr;
        i_data  = data;
        i_mask  = mask;
        @(negedge clk);
        i_wr_en = 1'b0;
        i_rd_en = 1'b0;
        check_value("o_busy", o_busy, 1'b1);
        while (o_busy) begin
            @(negedge clk);
        end
        if (!wr) begin
            check_value("o_data", o_data, word);
        end
    endtask

    // every completed application request against the expected order
    always @(negedge clk) begin
        if (seen_stb) begin
            if (exp_cmd_q.size() == 0) begin
                $display("a command was issued with no request pending");
                $display("FAIL: see errors above");
                $fatal(1, "extra command");
            end else begin
                exp_cmd = exp_cmd_q.pop_front();
                check_value("o_app_cmd", seen_cmd, exp_cmd);
                check_value("o_app_addr", seen_addr, exp_addr_q.pop_front());
                if (exp_cmd == dram_app_pkg::CMD_WRITE) begin
                    check_value("o_app_wdf_data", seen_data, exp_data_q.pop_front());
                    check_value("o_app_wdf_mask", seen_mask, exp_mask_q.pop_front());
                end else begin
                    void'(exp_data_q.pop_front());
                    void'(exp_mask_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(64929));
        rst_x_async = 1'b0;
        i_wr_en     = 1'b0;
        i_rd_en     = 1'b0;
        i_addr      = '0;
        i_data      = '0;
        i_mask      = '0;
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = $urandom;
        end
        repeat (10) @(negedge clk);
        rst_x_async <= 1'b1;
        @(negedge clk);
        check_value("o_app_en", app_en, 1'b0);
        check_value("o_app_wdf_wren", wdf_wren, 1'b0);
        while (!calib) begin
            check_value("o_busy", o_busy, 1'b1);
            @(negedge clk);
        end
        while (o_busy) begin
            @(negedge clk);
        end
        // mostly writes so that runs of them back up the queue
        for (int n = 0; n < NUM_REQ; n++) begin
            send_request(($urandom % 10) < 7, pool[$urandom % POOL_SIZE], $urandom,
                         4'($urandom));
        end
        for (int i = 0; i < POOL_SIZE; i++) begin
            send_request(1'b0, pool[i], '0, '0);
        end
        while (exp_cmd_q.size() != 0) begin
            @(negedge clk);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: dram_ctrl.f
dram_geom_pkg.sv
dram_app_pkg.sv
dram_req_if.sv
user_req_stage.sv
req_queue.sv
app_cmd_issuer.sv
dram_ctrl_top.sv
dram_app_model.sv
dram_ctrl_properties.sv
dram_ctrl_tb.sv
